/* source/smac_cfg_pkg.sv */
// slice geometry is fixed at four lanes packed into one 64-bit word; lane widths must sum to SMAC_DATA_W
package smac_cfg_pkg;

  //////////////////////////////
  // word level
  //////////////////////////////

  localparam int unsigned SMAC_DATA_W    = 64; // data, weight, psum and result bus width
  localparam int unsigned SMAC_NUM_LANES = 4;  // int8 lo, int8 hi, int16, int32

  //////////////////////////////
  // lane layout
  //////////////////////////////

  // index 0 is the lowest lane, the order matches the lane flag struct bit order
  // lane 0 -> int8_lo, lane 1 -> int8_hi, lane 2 -> int16, lane 3 -> int32

  localparam logic [SMAC_NUM_LANES-1:0][31:0] SMAC_LANE_W = {
    32'd32, // lane 3, 32-bit lane
    32'd16, // lane 2, 16-bit lane
    32'd8,  // lane 1, upper 8-bit lane
    32'd8   // lane 0, lower 8-bit lane
  };

  localparam logic [SMAC_NUM_LANES-1:0][31:0] SMAC_LANE_LSB = {
    32'd32, // lane 3 sits on bits 63:32
    32'd16, // lane 2 sits on bits 31:16
    32'd8,  // lane 1 sits on bits 15:8
    32'd0   // lane 0 sits on bits 7:0
  };

  // lanes are contiguous, so lsb of lane n+1 = lsb + width of lane n
  // the top level relies on this to cover every result bit exactly once

endpackage

/* source/smac_types_pkg.sv */
// mode codes above MODE_ALL are treated as idle; operand struct is data in the top bits, psum lowest
package smac_types_pkg;

  import smac_cfg_pkg::*;

  //////////////////////////////
  // precision mode
  //////////////////////////////

  typedef enum logic [2:0] {
    MODE_IDLE  = 3'd0, // no lane loads
    MODE_INT8  = 3'd1, // both 8-bit lanes
    MODE_INT16 = 3'd2, // 16-bit lane only
    MODE_INT32 = 3'd3, // 32-bit lane only
    MODE_ALL   = 3'd4  // every lane at once
  } smac_mode_e;

  //////////////////////////////
  // operand bundle
  //////////////////////////////

  typedef struct packed {
    logic [SMAC_DATA_W-1:0] data;   // multiplicand word
    logic [SMAC_DATA_W-1:0] weight; // multiplier word
    logic [SMAC_DATA_W-1:0] psum;   // incoming partial sum word
  } smac_operands_t; // 192 bits

  //////////////////////////////
  // per lane flags
  //////////////////////////////

  // bit order follows lane index, int8_lo is bit 0
  // used for lane enables, load strobes and result valids
  typedef struct packed {
    logic int32;   // lane 3, bits 63:32
    logic int16;   // lane 2, bits 31:16
    logic int8_hi; // lane 1, bits 15:8
    logic int8_lo; // lane 0, bits 7:0
  } smac_lane_flags_t; // 4 bits

endpackage

/* source/smac_ctrl.sv */
// ce_i low freezes all flags; sclr_i clears flags even when ce_i is low; load strobes are combinational
`timescale 1ns/100ps

module smac_ctrl
  import smac_cfg_pkg::*;
  import smac_types_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             ce_i,        // global clock enable
  input  logic             sclr_i,      // synchronous clear
  input  smac_mode_e       mode_i,      // precision select
  output smac_lane_flags_t ld_s1_o,     // product register load per lane
  output smac_lane_flags_t ld_s2_o,     // result register load per lane
  output smac_lane_flags_t res_valid_o  // fresh result per lane
);

  smac_lane_flags_t          lane_sel; // lanes picked by the mode
  logic [SMAC_NUM_LANES-1:0] ce_mask;  // ce fanned out to every lane
  logic [SMAC_NUM_LANES-1:0] vld_s1_q; // stage 1 holds an item
  logic [SMAC_NUM_LANES-1:0] vld_s2_q; // stage 2 holds a fresh result

  //////////////////////////////
  // mode decode
  //////////////////////////////

  always_comb begin
    lane_sel = '0; // idle unless the mode says otherwise
    case (mode_i)
      MODE_INT8: begin
        lane_sel.int8_lo = 1'b1; // both byte lanes
        lane_sel.int8_hi = 1'b1;
      end
      MODE_INT16: lane_sel.int16 = 1'b1;
      MODE_INT32: lane_sel.int32 = 1'b1;
      MODE_ALL:   lane_sel       = '1;  // full word, all lanes
      default:    lane_sel       = '0;  // MODE_IDLE and spare codes
    endcase
  end

  //////////////////////////////
  // enable network
  //////////////////////////////

  assign ce_mask = {SMAC_NUM_LANES{ce_i}};

  // stage 1 loads on ce and mode select
  assign ld_s1_o = smac_lane_flags_t'(ce_mask & lane_sel);

  // stage 2 loads on ce and a live stage 1 item
  assign ld_s2_o = smac_lane_flags_t'(ce_mask & vld_s1_q);

  //////////////////////////////
  // valid pipeline
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_s1_q <= '0;
      vld_s2_q <= '0;
    end else if (sclr_i) begin
      vld_s1_q <= '0; // clear wins, ce is ignored
      vld_s2_q <= '0;
    end else if (ce_i) begin
      vld_s1_q <= lane_sel; // an unselected lane drops its stage 1 flag
      vld_s2_q <= vld_s1_q; // result valid trails stage 1 by one edge
    end
  end

  assign res_valid_o = smac_lane_flags_t'(vld_s2_q);

endmodule

/* source/smac_mac_lane.sv */
// unsigned multiply-add wrapping at LANE_W bits; the lane only sees load strobes and never ce or mode
`timescale 1ns/100ps

module smac_mac_lane #(
  parameter int unsigned LANE_W = 8 // 8, 16 or 32
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              sclr_i,  // synchronous clear of both stages
  input  logic              ld_s1_i, // load product and psum
  input  logic              ld_s2_i, // load sum into result
  input  logic [LANE_W-1:0] a_i,     // data slice
  input  logic [LANE_W-1:0] b_i,     // weight slice
  input  logic [LANE_W-1:0] c_i,     // psum slice
  output logic [LANE_W-1:0] p_o      // lane result
);

  logic [LANE_W-1:0] prod_d; // product, low LANE_W bits only
  logic [LANE_W-1:0] prod_q; // stage 1 product register
  logic [LANE_W-1:0] c_q;    // psum aligned with the product
  logic [LANE_W-1:0] sum_d;  // stage 2 adder
  logic [LANE_W-1:0] p_q;    // stage 2 result register

  //////////////////////////////
  // stage 1 multiply
  //////////////////////////////

  // upper product bits never reach the result, so the multiply is kept at lane width
  assign prod_d = a_i * b_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prod_q <= '0;
      c_q    <= '0;
    end else if (sclr_i) begin
      prod_q <= '0; // drop in-flight item
      c_q    <= '0;
    end else if (ld_s1_i) begin
      prod_q <= prod_d;
      c_q    <= c_i; // psum of the same cycle as a_i, b_i
    end
  end

  //////////////////////////////
  // stage 2 add
  //////////////////////////////

  assign sum_d = prod_q + c_q; // carry out discarded, mod 2^LANE_W

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      p_q <= '0;
    end else if (sclr_i) begin
      p_q <= '0; // result bits read zero after a clear
    end else if (ld_s2_i) begin
      p_q <= sum_d;
    end
    // no load -> result holds its last value
  end

  assign p_o = p_q;

endmodule

/* source/smac_top.sv */
// four fixed lanes over one 64-bit word; latency is two enabled cycles and ce_i low stalls everything
`timescale 1ns/100ps

module smac_top
  import smac_cfg_pkg::*;
  import smac_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   ce_i,        // global clock enable, stalls the pipe
  input  logic                   sclr_i,      // synchronous clear, wins over ce
  input  smac_mode_e             mode_i,      // precision select
  input  smac_operands_t         ops_i,       // data, weight, psum
  output wire  [SMAC_DATA_W-1:0] res_o,       // lane results at lane positions
  output smac_lane_flags_t       res_valid_o  // one valid per lane
);

  smac_lane_flags_t          ld_s1;     // stage 1 strobes from control
  smac_lane_flags_t          ld_s2;     // stage 2 strobes from control
  logic [SMAC_NUM_LANES-1:0] ld_s1_vec; // strobes by lane index
  logic [SMAC_NUM_LANES-1:0] ld_s2_vec;

  //////////////////////////////
  // control
  //////////////////////////////

  smac_ctrl u_ctrl (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ce_i        (ce_i),
    .sclr_i      (sclr_i),
    .mode_i      (mode_i),
    .ld_s1_o     (ld_s1),
    .ld_s2_o     (ld_s2),
    .res_valid_o (res_valid_o)
  );

  // flag struct bit n is lane n
  assign ld_s1_vec = ld_s1;
  assign ld_s2_vec = ld_s2;

  //////////////////////////////
  // lanes
  //////////////////////////////

  for (genvar i = 0; i < SMAC_NUM_LANES; i++) begin : g_lane
    localparam int unsigned LW  = SMAC_LANE_W[i];   // lane width
    localparam int unsigned LSB = SMAC_LANE_LSB[i]; // lane low bit

    smac_mac_lane #(
      .LANE_W (LW)
    ) u_lane (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .sclr_i  (sclr_i),
      .ld_s1_i (ld_s1_vec[i]),
      .ld_s2_i (ld_s2_vec[i]),
      .a_i     (ops_i.data[LSB +: LW]),   // data slice
      .b_i     (ops_i.weight[LSB +: LW]), // weight slice
      .c_i     (ops_i.psum[LSB +: LW]),   // psum slice
      .p_o     (res_o[LSB +: LW])         // result back in place
    );
  end

endmodule

/* tb/smac_tb.sv */
// model advances only on ce_i high edges; spare mode codes above MODE_ALL are never driven
`timescale 1ns/100ps

module smac_tb
  import smac_cfg_pkg::*;
  import smac_types_pkg::*;
#(
  parameter int SEED = 92945 // start value of the random seed
);

  localparam int RESET_CYCLES = 5;
  localparam int FLUSH_CYCLES = 3;               // drains two stages plus margin
  localparam int STIM_CYCLES  = 200;             // rough length of all tests
  localparam int CYCLE_LIMIT  = 10 * STIM_CYCLES;

  logic                   clk = 1'b0;
  logic                   rst_n_i;
  logic                   ce_i;
  logic                   sclr_i;
  smac_mode_e             mode_i;
  smac_operands_t         ops_i;
  logic [SMAC_DATA_W-1:0] res_o;
  smac_lane_flags_t       res_valid_o;

  int seed;
  int err_cnt       = 0; // failed checks over the whole run
  int test_err_base = 0; // err_cnt when the current test began
  int test_cnt      = 0;
  int fail_tests    = 0;
  int cycle_cnt     = 0;

  logic [32:0]            pipe_q [SMAC_NUM_LANES][$]; // {selected, expected value} per item
  logic [SMAC_DATA_W-1:0] exp_res = '0;               // expected res_o
  logic [SMAC_NUM_LANES-1:0] exp_vld = '0;            // expected res_valid_o

  always #50 clk = ~clk; // 100 ns period

  smac_top u_dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ce_i        (ce_i),
    .sclr_i      (sclr_i),
    .mode_i      (mode_i),
    .ops_i       (ops_i),
    .res_o       (res_o),
    .res_valid_o (res_valid_o)
  );

  //////////////////////////////
  // expected value helpers
  //////////////////////////////

  // each lane works in its own mode and in MODE_ALL
  function automatic smac_lane_flags_t mode_lanes(input smac_mode_e mode);
    smac_lane_flags_t m;
    m.int8_lo = (mode == MODE_INT8) || (mode == MODE_ALL);
    m.int8_hi = (mode == MODE_INT8) || (mode == MODE_ALL);
    m.int16   = (mode == MODE_INT16) || (mode == MODE_ALL);
    m.int32   = (mode == MODE_INT32) || (mode == MODE_ALL);
    return m;
  endfunction

  // bits of lane l in place on the 64-bit word
  function automatic logic [63:0] lane_field(input int l);
    return ((64'd1 << SMAC_LANE_W[l]) - 64'd1) << SMAC_LANE_LSB[l];
  endfunction

  // (data x weight + psum) mod 2^W for lane l
  function automatic logic [31:0] expected_mac(input smac_operands_t ops, input int l);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [63:0] full;
    a    = 32'(ops.data >> SMAC_LANE_LSB[l]);
    b    = 32'(ops.weight >> SMAC_LANE_LSB[l]);
    c    = 32'(ops.psum >> SMAC_LANE_LSB[l]);
    full = 64'(a) * 64'(b) + 64'(c); // low W bits depend only on low W operand bits
    return 32'(full & ((64'd1 << SMAC_LANE_W[l]) - 64'd1));
  endfunction

  function automatic smac_operands_t random_ops();
    smac_operands_t ops;
    ops.data   = {$random(seed), $random(seed)};
    ops.weight = {$random(seed), $random(seed)};
    ops.psum   = {$random(seed), $random(seed)};
    return ops;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  always @(posedge clk or negedge rst_n_i) begin : ref_model
    smac_lane_flags_t sel;
    logic [32:0]      item;
    logic [63:0]      field;
    if (!rst_n_i || sclr_i) begin
      for (int l = 0; l < SMAC_NUM_LANES; l++) pipe_q[l].delete(); // in-flight items gone
      exp_res = '0;
      exp_vld = '0;
    end else if (ce_i) begin // stalled cycles leave the model untouched
      sel = mode_lanes(mode_i);
      for (int l = 0; l < SMAC_NUM_LANES; l++) begin
        pipe_q[l].push_back({sel[l], expected_mac(ops_i, l)});
        if (pipe_q[l].size() > 1) begin
          item       = pipe_q[l].pop_front();
          exp_vld[l] = item[32]; // bubble clears valid
          if (item[32]) begin
            field   = lane_field(l);
            exp_res = (exp_res & ~field) | ((64'(item[31:0]) << SMAC_LANE_LSB[l]) & field);
          end // bubble keeps the old result bits
        end
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_result: assert property (@(posedge clk) disable iff (!rst_n_i) res_o == exp_res)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: res_o %h, expected %h", $time, $sampled(res_o), $sampled(exp_res));
    end

  a_valid: assert property (@(posedge clk) disable iff (!rst_n_i) res_valid_o == exp_vld)
    else begin
      err_cnt++;
      $display("[ERROR] %0t: res_valid_o %b, expected %b", $time,
               $sampled(res_valid_o), $sampled(exp_vld));
    end

  // ce low without clear freezes every output
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      (!$past(ce_i) && !$past(sclr_i)) |-> ($stable(res_o) && $stable(res_valid_o)))
    else begin
      err_cnt++;
      $display("[ERROR] %0t: outputs moved during a stalled cycle", $time);
    end

  a_clear: assert property (@(posedge clk) disable iff (!rst_n_i)
      $past(sclr_i) |-> (res_o == '0 && res_valid_o == '0))
    else begin
      err_cnt++;
      $display("[ERROR] %0t: res_o %h valid %b not zero after clear", $time,
               $sampled(res_o), $sampled(res_valid_o));
    end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic drive(input smac_mode_e mode, input logic ce, input logic sclr);
    @(posedge clk);
    mode_i <= mode;
    ce_i   <= ce;
    sclr_i <= sclr;
    ops_i  <= random_ops(); // fresh operands every cycle whether used or not
  endtask

  task automatic burst(input smac_mode_e mode, input int n);
    repeat (n) drive(mode, 1'b1, 1'b0);
  endtask

  task automatic end_test(input string name);
    int n;
    burst(MODE_IDLE, FLUSH_CYCLES); // let the last items reach the checks
    n = err_cnt - test_err_base;
    test_cnt++;
    if (n != 0) fail_tests++;
    $display("test %0d %s: %s, %0d errors", test_cnt, name, (n == 0) ? "ok" : "failed", n);
    test_err_base = err_cnt;
  endtask

  always @(posedge clk) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles, tests did not finish", cycle_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin : main
    logic ce;
    seed    = SEED;
    rst_n_i = 1'b0;
    ce_i    = 1'b0;
    sclr_i  = 1'b0;
    mode_i  = MODE_IDLE;
    ops_i   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;

    repeat (4) drive(MODE_IDLE, 1'b0, 1'b0); // nothing loaded yet
    end_test("reset state");

    burst(MODE_INT8, 12);
    end_test("int8 lanes");

    burst(MODE_INT16, 12);
    burst(MODE_INT32, 12);
    end_test("int16 then int32");

    for (int g = 0; g < 4; g++) begin
      burst(MODE_ALL, 8);
      burst(MODE_IDLE, 3); // valids drop across the gap
    end
    end_test("all lanes with idle gaps");

    for (int k = 0; k < 40; k++) begin
      ce = ($unsigned($random(seed)) % 10) >= 3; // about 30 percent stalls
      drive(MODE_ALL, ce, 1'b0);
    end
    end_test("random stalls");

    burst(MODE_ALL, 5);
    drive(MODE_ALL, 1'b1, 1'b1); // clear while running
    burst(MODE_ALL, 4);
    drive(MODE_ALL, 1'b0, 1'b1); // clear while stalled
    burst(MODE_INT8, 3);
    drive(MODE_INT16, 1'b1, 1'b1);
    burst(MODE_ALL, 3);
    end_test("clear mid burst");

    repeat (2) @(posedge clk);
    $display("tests run %0d, tests failed %0d, check errors %0d", test_cnt, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* smac.f */
source/smac_cfg_pkg.sv
source/smac_types_pkg.sv
source/smac_ctrl.sv
source/smac_mac_lane.sv
source/smac_top.sv
tb/smac_tb.sv

/* Makefile */
# Verilator flow for the smac slice and its testbench
# usage: make sim SEED=1234 LOG=run.log

TOP       ?= smac_tb
RTL_TOP   ?= smac_top
SEED      ?= 92945
LOG       ?= sim.log
FILELIST  ?= smac.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --sv --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR) -o V$(TOP)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TB FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
